// ==== if_pkg.sv ====
////////////////////////////////////////////////////////////
// shared types and constants of the fetch stage
// all fetches are 32-bit words, no compressed instructions
////////////////////////////////////////////////////////////

package if_pkg;

  // byte address or raw instruction word
  typedef logic [31:0] addr_t;

  // next pc source selected by the controller
  typedef enum logic [2:0] {
    PC_BOOT = 3'd0,
    PC_JUMP = 3'd1,
    PC_EXC  = 3'd2,
    PC_ERET = 3'd3,
    PC_DRET = 3'd4
  } pc_sel_e;

  // target inside the exception path
  typedef enum logic [1:0] {
    EXC_PC_EXC     = 2'd0,
    EXC_PC_IRQ     = 2'd1,
    EXC_PC_DBD     = 2'd2,
    EXC_PC_DBG_EXC = 2'd3
  } exc_pc_sel_e;

  // boot pc sits at this offset above the aligned boot base
  localparam logic [7:0] BOOT_OFFSET  = 8'h80;
  // bits below this index are dropped from mtvec and boot address
  localparam int         VEC_BASE_LSB = 8;
  // internal interrupts all land in the nmi slot
  localparam logic [4:0] NMI_VEC      = 5'd31;

  localparam int QUEUE_DEPTH = 2;
  // fill level 0 .. QUEUE_DEPTH
  typedef logic [$clog2(QUEUE_DEPTH+1)-1:0] lvl_t;

endpackage

// ==== fetch_if.sv ====
////////////////////////////////////////////////////////////
// fetched word from the queue head towards the IF-ID register
// head moves on when valid and ready are high together
////////////////////////////////////////////////////////////

`timescale 1ns/1ns

interface fetch_if;
  import if_pkg::*;

  // queue holds at least one word
  logic  valid;
  // consumer takes the head this cycle
  logic  ready;
  addr_t rdata;
  // pc of the head word
  addr_t addr;
  // bus error seen on this word
  logic  err;

  modport src (output valid, output rdata, output addr, output err, input ready);
  modport dst (input valid, input rdata, input addr, input err, output ready);

endinterface

// ==== pc_sel.sv ====
////////////////////////////////////////////////////////////
// next pc and exception vector select, purely combinational
// mtvec and boot address are used from bit VEC_BASE_LSB up
////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module pc_sel #(
  parameter if_pkg::addr_t DM_HALT_ADDR = 32'h1A11_0800,
  parameter if_pkg::addr_t DM_EXC_ADDR  = 32'h1A11_0808
) (
  input  if_pkg::pc_sel_e     pc_mux_i,
  input  if_pkg::exc_pc_sel_e exc_pc_mux_i,
  input  logic                pc_set_i,
  input  logic                irq_int_i,
  input  logic [4:0]          exc_cause_i,
  input  if_pkg::addr_t       boot_addr_i,
  input  if_pkg::addr_t       branch_target_i,
  input  if_pkg::addr_t       csr_mepc_i,
  input  if_pkg::addr_t       csr_depc_i,
  input  if_pkg::addr_t       csr_mtvec_i,
  output if_pkg::addr_t       fetch_addr_n_o,
  output logic                csr_mtvec_init_o
);
  import if_pkg::*;

  addr_t      vec_base;
  addr_t      boot_pc;
  addr_t      exc_pc;
  logic [4:0] irq_vec;

  // aligned bases with the low bits cleared
  assign vec_base = {csr_mtvec_i[31:VEC_BASE_LSB], {VEC_BASE_LSB{1'b0}}};
  assign boot_pc  = {boot_addr_i[31:VEC_BASE_LSB], {VEC_BASE_LSB{1'b0}}} | addr_t'(BOOT_OFFSET);

  // internal irqs share the nmi slot
  assign irq_vec = irq_int_i ? NMI_VEC : exc_cause_i;

  always_comb begin
    unique case (exc_pc_mux_i)
      EXC_PC_EXC:     exc_pc = vec_base;
      // one word per vector slot
      EXC_PC_IRQ:     exc_pc = vec_base + addr_t'({irq_vec, 2'b00});
      EXC_PC_DBD:     exc_pc = DM_HALT_ADDR;
      EXC_PC_DBG_EXC: exc_pc = DM_EXC_ADDR;
      default:        exc_pc = vec_base;
    endcase
  end

  always_comb begin
    unique case (pc_mux_i)
      PC_BOOT: fetch_addr_n_o = boot_pc;
      PC_JUMP: fetch_addr_n_o = branch_target_i;
      PC_EXC:  fetch_addr_n_o = exc_pc;
      PC_ERET: fetch_addr_n_o = csr_mepc_i;
      PC_DRET: fetch_addr_n_o = csr_depc_i;
      default: fetch_addr_n_o = boot_pc;
    endcase
  end

  // csr file loads its mtvec reset value on boot
  assign csr_mtvec_init_o = pc_set_i & (pc_mux_i == PC_BOOT);

endmodule

// ==== fetch_fsm.sv ====
////////////////////////////////////////////////////////////
// bus sequencer, one request outstanding at a time
// a branch after grant turns the pending response stale
////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module fetch_fsm (
  input  logic         clk_i,
  input  logic         rst_ni,
  input  logic         req_i,
  input  logic         branch_i,
  input  logic         instr_gnt_i,
  input  logic         instr_rvalid_i,
  input  if_pkg::lvl_t level_i,
  output logic         instr_req_o,
  output logic         gnt_o,
  output logic         push_o,
  output logic         busy_o
);
  import if_pkg::*;

  typedef enum logic [1:0] {IDLE, REQ, WAIT, WAIT_DROP} state_e;

  state_e state_q, state_d;
  logic   pending;
  logic   room;

  // a live response in flight takes one queue slot
  assign pending = (state_q == WAIT);
  assign room    = (level_i + pending) < QUEUE_DEPTH;

  //////////////////////////////////////////////////////////////
  // next state
  //////////////////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      // a branch flushes the queue so there is always room
      IDLE: begin
        if (req_i && (branch_i || room)) begin
          state_d = REQ;
        end
      end
      // request is held until granted, address may change on branch
      REQ: begin
        if (instr_gnt_i) begin
          state_d = branch_i ? WAIT_DROP : WAIT;
        end
      end
      WAIT: begin
        if (instr_rvalid_i) begin
          state_d = (req_i && (branch_i || room)) ? REQ : IDLE;
        end else if (branch_i) begin
          state_d = WAIT_DROP;
        end
      end
      // swallow the stale response
      WAIT_DROP: begin
        if (instr_rvalid_i) begin
          state_d = (req_i && (branch_i || room)) ? REQ : IDLE;
        end
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  assign instr_req_o = (state_q == REQ);
  // request address steps on every grant
  assign gnt_o       = (state_q == REQ) & instr_gnt_i;
  // response racing a branch belongs to the old stream
  assign push_o      = (state_q == WAIT) & instr_rvalid_i & ~branch_i;
  assign busy_o      = (state_q != IDLE);

endmodule

// ==== fetch_addr_cnt.sv ====
////////////////////////////////////////////////////////////
// request and head address counters, word aligned
// branch load wins over a step in the same cycle
////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module fetch_addr_cnt (
  input  logic          clk_i,
  input  logic          rst_ni,
  input  logic          branch_i,
  input  if_pkg::addr_t branch_addr_i,
  input  logic          gnt_i,
  input  logic          pop_i,
  output if_pkg::addr_t req_addr_o,
  output if_pkg::addr_t head_addr_o
);

  // request side follows the bus grants
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      req_addr_o <= '0;
    end else if (branch_i) begin
      req_addr_o <= {branch_addr_i[31:2], 2'b00};
    end else if (gnt_i) begin
      req_addr_o <= req_addr_o + 32'd4;
    end
  end

  // head side follows words leaving the queue
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      head_addr_o <= '0;
    end else if (branch_i) begin
      head_addr_o <= {branch_addr_i[31:2], 2'b00};
    end else if (pop_i) begin
      head_addr_o <= head_addr_o + 32'd4;
    end
  end

endmodule

// ==== fetch_queue.sv ====
////////////////////////////////////////////////////////////
// small FIFO of fetched words with error flags
// never pushed when full, the sequencer checks the level
////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module fetch_queue (
  input  logic          clk_i,
  input  logic          rst_ni,
  input  logic          flush_i,
  input  logic          push_i,
  input  if_pkg::addr_t rdata_i,
  input  logic          err_i,
  output if_pkg::lvl_t  level_o,
  fetch_if.src          out
);
  import if_pkg::*;

  localparam int PTR_W = $clog2(QUEUE_DEPTH);

  addr_t            data_q [QUEUE_DEPTH];
  logic             err_q  [QUEUE_DEPTH];
  logic [PTR_W-1:0] rd_ptr_q, wr_ptr_q;
  lvl_t             level_q;
  logic             pop;

  assign pop = out.valid & out.ready;

  // pointers wrap on their own width, depth is a power of two
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      level_q  <= '0;
    end else if (flush_i) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      level_q  <= '0;
    end else begin
      if (push_i) wr_ptr_q <= wr_ptr_q + 1'b1;
      if (pop) rd_ptr_q <= rd_ptr_q + 1'b1;
      // push together with pop keeps the level
      if (push_i && !pop) begin
        level_q <= level_q + 1'b1;
      end else if (pop && !push_i) begin
        level_q <= level_q - 1'b1;
      end
    end
  end

  // storage
  always_ff @(posedge clk_i) begin
    if (push_i && !flush_i) begin
      data_q[wr_ptr_q] <= rdata_i;
      err_q[wr_ptr_q]  <= err_i;
    end
  end

  assign out.valid = (level_q != '0);
  assign out.rdata = data_q[rd_ptr_q];
  assign out.err   = err_q[rd_ptr_q];
  assign level_o   = level_q;

endmodule

// ==== if_id_reg.sv ====
////////////////////////////////////////////////////////////
// IF-ID pipeline register and sequential pc check
// payload is written whenever a word is taken, valid is not
////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module if_id_reg (
  input  logic          clk_i,
  input  logic          rst_ni,
  input  logic          id_in_ready_i,
  input  logic          pc_set_i,
  input  logic          instr_valid_clear_i,
  fetch_if.dst          in,
  output logic          instr_valid_id_o,
  output logic          instr_new_id_o,
  output if_pkg::addr_t instr_rdata_id_o,
  output logic          instr_fetch_err_o,
  output if_pkg::addr_t pc_id_o,
  output logic          pc_mismatch_alert_o
);

  logic new_d;
  logic valid_d;
  logic seq_q, seq_d;

  assign in.ready = id_in_ready_i;
  assign new_d    = in.valid & in.ready;

  // a word taken during a pc set is squashed
  // valid holds until ID clears it
  assign valid_d = (new_d & ~pc_set_i) | (instr_valid_id_o & ~instr_valid_clear_i);

  // sequence tracking restarts after any redirect or faulty fetch
  assign seq_d = (seq_q | new_d) & ~pc_set_i & ~in.err;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      instr_valid_id_o <= 1'b0;
      instr_new_id_o   <= 1'b0;
      seq_q            <= 1'b0;
    end else begin
      instr_valid_id_o <= valid_d;
      instr_new_id_o   <= new_d;
      seq_q            <= seq_d;
    end
  end

  // payload
  always_ff @(posedge clk_i) begin
    if (new_d) begin
      instr_rdata_id_o  <= in.rdata;
      instr_fetch_err_o <= in.err;
      pc_id_o           <= in.addr;
    end
  end

  // head must be the word right after the one in ID
  assign pc_mismatch_alert_o = seq_q & (in.addr != pc_id_o + 32'd4);

endmodule

// ==== if_stage_top.sv ====
////////////////////////////////////////////////////////////
// instruction fetch stage, word fetches on a req/gnt/rvalid bus
// boot address must be aligned to 256 bytes
////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module if_stage_top #(
  parameter if_pkg::addr_t DM_HALT_ADDR = 32'h1A11_0800,
  parameter if_pkg::addr_t DM_EXC_ADDR  = 32'h1A11_0808
) (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                req_i,
  input  if_pkg::addr_t       boot_addr_i,
  // control from ID
  input  logic                pc_set_i,
  input  if_pkg::pc_sel_e     pc_mux_i,
  input  if_pkg::exc_pc_sel_e exc_pc_mux_i,
  input  logic                irq_int_i,
  input  logic [4:0]          exc_cause_i,
  input  if_pkg::addr_t       branch_target_ex_i,
  input  if_pkg::addr_t       csr_mepc_i,
  input  if_pkg::addr_t       csr_depc_i,
  input  if_pkg::addr_t       csr_mtvec_i,
  input  logic                id_in_ready_i,
  input  logic                instr_valid_clear_i,
  // instruction bus
  input  logic                instr_gnt_i,
  input  logic                instr_rvalid_i,
  input  if_pkg::addr_t       instr_rdata_i,
  input  logic                instr_bus_err_i,
  output logic                instr_req_o,
  output if_pkg::addr_t       instr_addr_o,
  output logic                csr_mtvec_init_o,
  // to ID
  output logic                instr_valid_id_o,
  output logic                instr_new_id_o,
  output if_pkg::addr_t       instr_rdata_id_o,
  output logic                instr_fetch_err_o,
  output if_pkg::addr_t       pc_id_o,
  output if_pkg::addr_t       pc_if_o,
  output logic                pc_mismatch_alert_o,
  output logic                if_busy_o
);
  import if_pkg::*;

  addr_t fetch_addr_n;
  addr_t head_addr;
  lvl_t  level;
  logic  gnt;
  logic  push;
  logic  pop;

  fetch_if fetch ();

  // head pc rides along with the queue output
  assign fetch.addr = head_addr;
  assign pop        = fetch.valid & fetch.ready;
  assign pc_if_o    = head_addr;

  pc_sel #(
    .DM_HALT_ADDR (DM_HALT_ADDR),
    .DM_EXC_ADDR  (DM_EXC_ADDR)
  ) i_pc_sel (
    .pc_mux_i         (pc_mux_i),
    .exc_pc_mux_i     (exc_pc_mux_i),
    .pc_set_i         (pc_set_i),
    .irq_int_i        (irq_int_i),
    .exc_cause_i      (exc_cause_i),
    .boot_addr_i      (boot_addr_i),
    .branch_target_i  (branch_target_ex_i),
    .csr_mepc_i       (csr_mepc_i),
    .csr_depc_i       (csr_depc_i),
    .csr_mtvec_i      (csr_mtvec_i),
    .fetch_addr_n_o   (fetch_addr_n),
    .csr_mtvec_init_o (csr_mtvec_init_o)
  );

  fetch_fsm i_fetch_fsm (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .req_i          (req_i),
    .branch_i       (pc_set_i),
    .instr_gnt_i    (instr_gnt_i),
    .instr_rvalid_i (instr_rvalid_i),
    .level_i        (level),
    .instr_req_o    (instr_req_o),
    .gnt_o          (gnt),
    .push_o         (push),
    .busy_o         (if_busy_o)
  );

  fetch_addr_cnt i_fetch_addr_cnt (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .branch_i      (pc_set_i),
    .branch_addr_i (fetch_addr_n),
    .gnt_i         (gnt),
    .pop_i         (pop),
    .req_addr_o    (instr_addr_o),
    .head_addr_o   (head_addr)
  );

  fetch_queue i_fetch_queue (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .flush_i (pc_set_i),
    .push_i  (push),
    .rdata_i (instr_rdata_i),
    .err_i   (instr_bus_err_i),
    .level_o (level),
    .out     (fetch.src)
  );

  if_id_reg i_if_id_reg (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .id_in_ready_i       (id_in_ready_i),
    .pc_set_i            (pc_set_i),
    .instr_valid_clear_i (instr_valid_clear_i),
    .in                  (fetch.dst),
    .instr_valid_id_o    (instr_valid_id_o),
    .instr_new_id_o      (instr_new_id_o),
    .instr_rdata_id_o    (instr_rdata_id_o),
    .instr_fetch_err_o   (instr_fetch_err_o),
    .pc_id_o             (pc_id_o),
    .pc_mismatch_alert_o (pc_mismatch_alert_o)
  );

endmodule

// ==== tb_if_stage.sv ====
////////////////////////////////////////////////////////////
// testbench for the fetch stage with a randomized memory model
// memory returns address ^ 5a5a0000 and flags bus errors in 2000..20ff
////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module tb_if_stage;
  import if_pkg::*;

  localparam addr_t DM_HALT  = 32'h0000_7800;
  localparam addr_t DM_EXC   = 32'h0000_7808;
  localparam addr_t DATA_KEY = 32'h5a5a_0000;
  localparam addr_t MTVEC    = 32'h0000_4001;
  localparam addr_t VEC_BASE = 32'h0000_4000;
  localparam int    TIMEOUT  = 200;

  logic clk_i = 1'b0;
  logic rst_ni, req_i, pc_set_i, irq_int_i, ready_rand;
  logic instr_valid_clear_i = 1'b0;
  logic instr_gnt_i = 1'b0;
  logic instr_rvalid_i = 1'b0;
  logic instr_bus_err_i = 1'b0;
  addr_t instr_rdata_i = 32'hdead_beef;
  logic id_in_ready_i;
  pc_sel_e pc_mux_i;
  exc_pc_sel_e exc_pc_mux_i;
  logic [4:0] exc_cause_i;
  addr_t boot_addr_i, branch_target_ex_i, csr_mepc_i, csr_depc_i, csr_mtvec_i;
  logic instr_req_o, csr_mtvec_init_o, instr_valid_id_o, instr_new_id_o;
  logic instr_fetch_err_o, pc_mismatch_alert_o, if_busy_o;
  addr_t instr_addr_o, instr_rdata_id_o, pc_id_o, pc_if_o;

  // memory model and reference state
  logic [31:0] rnd = 32'h8f51;
  int gnt_wait = 0;
  int rsp_wait = 0;
  logic rsp_busy = 1'b0;
  addr_t rsp_addr = '0;
  addr_t exp_target, exp_pc, exp_rdata;
  logic quiet_phase, exp_err, exp_mtvec_init;
  logic [4:0] idle_bits;

  if_stage_top #(.DM_HALT_ADDR(DM_HALT), .DM_EXC_ADDR(DM_EXC)) i_if_stage_top (.*);

  always #50 clk_i = ~clk_i;

  // ID never takes a word in the redirect cycle
  assign id_in_ready_i  = ready_rand & ~pc_set_i;
  assign exp_rdata      = exp_pc ^ DATA_KEY;
  assign exp_err        = (exp_pc >= 32'h2000) && (exp_pc < 32'h2100);
  assign idle_bits = {instr_req_o, instr_valid_id_o, instr_new_id_o, if_busy_o,
                      pc_mismatch_alert_o};

  function automatic logic [31:0] next_rand(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic end_with_failure();
    $display("TESTS FAILED");
    $fatal(1, "simulation stopped on first error");
  endtask

  task automatic report_mismatch(input string name, input addr_t got, input addr_t exp);
    $display("** Error at %0t ns: %s = 0x%08h, expected 0x%08h", $time, name, got, exp);
    end_with_failure();
  endtask

  task automatic stop_on_timeout(input string what);
    $display("timeout after %0d cycles: %s", TIMEOUT, what);
    end_with_failure();
  endtask

  task automatic step();
    @(posedge clk_i);
    #5;
  endtask

  //////////////////////////////////////////////////////////////
  // memory model and ID side driven 5 ns after the edge
  //////////////////////////////////////////////////////////////

  always @(posedge clk_i) begin
    #5;
    rnd = next_rand(rnd);
    // ID stalls about one cycle in four
    ready_rand = (rnd[1:0] != 2'b00);
    instr_valid_clear_i = instr_new_id_o;
    instr_rvalid_i = 1'b0;
    instr_rdata_i = 32'hdead_beef;
    if (instr_gnt_i) begin
      // request was taken at the last edge
      instr_gnt_i = 1'b0;
      rsp_busy = 1'b1;
      rsp_wait = int'(rnd[5:4]) % 3;
    end else if (instr_req_o) begin
      if (gnt_wait == 0) begin
        instr_gnt_i = 1'b1;
        rsp_addr = instr_addr_o;
        gnt_wait = int'(rnd[9:8]);
      end else begin
        gnt_wait = gnt_wait - 1;
      end
    end
    if (rsp_busy) begin
      if (rsp_wait == 0) begin
        instr_rvalid_i = 1'b1;
        instr_rdata_i = rsp_addr ^ DATA_KEY;
        instr_bus_err_i = (rsp_addr >= 32'h2000) && (rsp_addr < 32'h2100);
        rsp_busy = 1'b0;
      end else begin
        rsp_wait = rsp_wait - 1;
      end
    end
  end

  // expected pc of the next word to reach ID
  always @(posedge clk_i) begin
    if (pc_set_i) begin
      exp_pc <= {exp_target[31:2], 2'b00};
    end else if (instr_new_id_o) begin
      exp_pc <= exp_pc + 32'd4;
    end
  end

  //////////////////////////////////////////////////////////////
  // checks
  //////////////////////////////////////////////////////////////

  a_quiet: assert property (@(posedge clk_i) quiet_phase |-> idle_bits == 5'b0)
    else report_mismatch("{req,valid,new,busy,alert}", 32'($sampled(idle_bits)), '0);
  a_mtvec: assert property (@(posedge clk_i) disable iff (!rst_ni)
      csr_mtvec_init_o == exp_mtvec_init)
    else report_mismatch("csr_mtvec_init_o", 32'($sampled(csr_mtvec_init_o)),
                         32'($sampled(exp_mtvec_init)));
  a_pc: assert property (@(posedge clk_i) disable iff (!rst_ni)
      instr_new_id_o |-> pc_id_o == exp_pc)
    else report_mismatch("pc_id_o", $sampled(pc_id_o), $sampled(exp_pc));
  // head sits one word past the instruction just handed to ID
  a_pc_if: assert property (@(posedge clk_i) disable iff (!rst_ni)
      instr_new_id_o |-> pc_if_o == exp_pc + 32'd4)
    else report_mismatch("pc_if_o", $sampled(pc_if_o), $sampled(exp_pc) + 32'd4);
  a_rdata: assert property (@(posedge clk_i) disable iff (!rst_ni)
      instr_new_id_o |-> instr_rdata_id_o == exp_rdata)
    else report_mismatch("instr_rdata_id_o", $sampled(instr_rdata_id_o), $sampled(exp_rdata));
  a_err: assert property (@(posedge clk_i) disable iff (!rst_ni)
      instr_new_id_o |-> instr_fetch_err_o == exp_err)
    else report_mismatch("instr_fetch_err_o", 32'($sampled(instr_fetch_err_o)),
                         32'($sampled(exp_err)));
  a_alert: assert property (@(posedge clk_i) disable iff (!rst_ni) !pc_mismatch_alert_o)
    else report_mismatch("pc_mismatch_alert_o", 32'd1, 32'd0);
  a_align: assert property (@(posedge clk_i) disable iff (!rst_ni)
      instr_req_o |-> instr_addr_o[1:0] == 2'b00)
    else report_mismatch("instr_addr_o", $sampled(instr_addr_o),
                         {$sampled(instr_addr_o[31:2]), 2'b00});

  // one-cycle pc_set with the expected target from the selection rules
  task automatic redirect(input pc_sel_e sel, input exc_pc_sel_e esel, input logic irq_int,
                          input logic [4:0] cause, input addr_t target);
    pc_mux_i = sel;
    exc_pc_mux_i = esel;
    irq_int_i = irq_int;
    exc_cause_i = cause;
    exp_target = target;
    // only a boot redirect asks the CSR file for its mtvec reset value
    exp_mtvec_init = (sel == PC_BOOT);
    pc_set_i = 1'b1;
    step();
    pc_set_i = 1'b0;
    exp_mtvec_init = 1'b0;
  endtask

  task automatic wait_new_instrs(input int count);
    int seen;
    int cycles;
    seen = 0;
    cycles = 0;
    while (seen < count && cycles < TIMEOUT) begin
      step();
      cycles++;
      if (instr_new_id_o) seen++;
    end
    if (seen < count) stop_on_timeout("too few new instructions reached ID");
  endtask

  // busy without a request means a response is still outstanding
  task automatic wait_resp_pending();
    int cycles;
    cycles = 0;
    while (!(if_busy_o && !instr_req_o) && cycles < TIMEOUT) begin
      step();
      cycles++;
    end
    if (!(if_busy_o && !instr_req_o)) stop_on_timeout("no bus response became pending");
  endtask

  initial begin
    rst_ni = 1'b0;
    req_i = 1'b0;
    pc_set_i = 1'b0;
    irq_int_i = 1'b0;
    ready_rand = 1'b0;
    pc_mux_i = PC_BOOT;
    exc_pc_mux_i = EXC_PC_EXC;
    exc_cause_i = '0;
    boot_addr_i = 32'h0000_1000;
    branch_target_ex_i = 32'h0000_2403;
    csr_mepc_i = 32'h0000_3000;
    csr_depc_i = 32'h0000_3202;
    csr_mtvec_i = MTVEC;
    exp_target = '0;
    exp_mtvec_init = 1'b0;
    quiet_phase = 1'b1;
    repeat (10) @(posedge clk_i);
    #5;
    rst_ni = 1'b1;
    repeat (20) step();
    quiet_phase = 1'b0;
    // boot pc is the aligned base with offset 80
    req_i = 1'b1;
    redirect(PC_BOOT, EXC_PC_EXC, 1'b0, 5'd0, 32'h0000_1080);
    wait_new_instrs(16);
    redirect(PC_JUMP, EXC_PC_EXC, 1'b0, 5'd0, 32'h0000_2403);
    wait_new_instrs(6);
    // jump with a response in flight
    branch_target_ex_i = 32'h0000_2800;
    wait_resp_pending();
    redirect(PC_JUMP, EXC_PC_EXC, 1'b0, 5'd0, 32'h0000_2800);
    wait_new_instrs(6);
    redirect(PC_ERET, EXC_PC_EXC, 1'b0, 5'd0, 32'h0000_3000);
    wait_new_instrs(5);
    redirect(PC_DRET, EXC_PC_EXC, 1'b0, 5'd0, 32'h0000_3202);
    wait_new_instrs(5);
    // exception vectors
    redirect(PC_EXC, EXC_PC_EXC, 1'b0, 5'd0, VEC_BASE);
    wait_new_instrs(4);
    redirect(PC_EXC, EXC_PC_IRQ, 1'b0, 5'd5, VEC_BASE + 32'd20);
    wait_new_instrs(4);
    redirect(PC_EXC, EXC_PC_IRQ, 1'b1, 5'd5, VEC_BASE + 32'd124);
    wait_new_instrs(4);
    redirect(PC_EXC, EXC_PC_DBD, 1'b0, 5'd0, DM_HALT);
    wait_new_instrs(4);
    redirect(PC_EXC, EXC_PC_DBG_EXC, 1'b0, 5'd0, DM_EXC);
    wait_new_instrs(4);
    // four faulty words and clean ones past the window
    branch_target_ex_i = 32'h0000_20f0;
    redirect(PC_JUMP, EXC_PC_EXC, 1'b0, 5'd0, 32'h0000_20f0);
    wait_new_instrs(8);
    repeat (5) step();
    $display("TESTS PASSED");
    $finish;
  end

endmodule

// ==== vlog.f ====
if_pkg.sv
fetch_if.sv
pc_sel.sv
fetch_fsm.sv
fetch_addr_cnt.sv
fetch_queue.sv
if_id_reg.sv
if_stage_top.sv
tb_if_stage.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= tb_if_stage
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

SIM_BIN := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	grep -q "^TESTS PASSED$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
